// ==== verilog/calc_params.svh ====
`ifndef CALC_PARAMS_SVH
`define CALC_PARAMS_SVH

// operation select codes
`define CALC_OP_ADD  2'b00               // x plus y
`define CALC_OP_SUB  2'b01               // x minus y
`define CALC_OP_MUL  2'b10               // x times y
`define CALC_OP_NONE 2'b11               // zero result, blank op digit

`define CALC_MAG_MAX 4'd9                // largest decimal magnitude

// active-low glyphs, bit order g down to a
`define CALC_GLYPH_BLANK 7'b1111111      // all segments off
`define CALC_GLYPH_MINUS 7'b0111111      // segment g only

`define CALC_OP_DIGIT_ADD 4'd2           // digit shown for add
`define CALC_OP_DIGIT_SUB 4'd4           // digit shown for sub
`define CALC_OP_DIGIT_MUL 4'd7           // digit shown for mul

`define CALC_REFRESH_TICKS 10000         // cycles per lit digit

`endif

// ==== verilog/calc_pkg.sv ====
package calc_pkg;

    ////////////////////////////////////////
    // operand side
    ////////////////////////////////////////

    typedef logic [3:0] magnitude_t;     // decimal magnitude 0 to 9

    typedef logic [4:0] operand_t;       // sign in bit 4, magnitude below

    typedef logic [1:0] op_code_t;       // add, sub, mul or none

    typedef logic [6:0] result_mag_t;    // result magnitude up to 81

    ////////////////////////////////////////
    // display side
    ////////////////////////////////////////

    typedef logic [2:0] digit_sel_t;     // scan position 0 to 7

    typedef logic [6:0] segments_t;      // active low, g down to a

    typedef logic [7:0] anode_t;         // active low, one per digit

endpackage

// ==== verilog/calc_display_if.sv ====
`timescale 1ns/1ps

// registered calculator state as seen by the display
interface calc_display_if;

    logic                   valid;       // registers loaded since reset
    calc_pkg::operand_t     x;           // clamped first operand
    calc_pkg::operand_t     y;           // clamped second operand
    calc_pkg::op_code_t     op;          // registered operation code
    calc_pkg::result_mag_t  result_mag;  // magnitude of the result
    logic                   result_neg;  // sign, never set for zero

    modport producer (
        output valid, x, y, op, result_mag, result_neg
    );

    modport consumer (
        input valid, x, y, op, result_mag, result_neg
    );

endinterface

// ==== verilog/segment_decoder.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

// decimal digit to active-low segments, bit order g down to a
module segment_decoder (
    input  calc_pkg::magnitude_t  digit,
    output calc_pkg::segments_t   sseg
);

    always_comb
    begin
        case (digit)
            4'd0:    sseg = 7'b1000000;      // all but g
            4'd1:    sseg = 7'b1111001;      // b c
            4'd2:    sseg = 7'b0100100;
            4'd3:    sseg = 7'b0110000;
            4'd4:    sseg = 7'b0011001;
            4'd5:    sseg = 7'b0010010;
            4'd6:    sseg = 7'b0000010;
            4'd7:    sseg = 7'b1111000;      // a b c
            4'd8:    sseg = 7'b0000000;      // every segment
            4'd9:    sseg = 7'b0010000;
            default: sseg = `CALC_GLYPH_BLANK; // 10 to 15 unlit
        endcase
    end

endmodule

// ==== verilog/operand_calculator.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module operand_calculator (
    input  logic                clk,
    input  logic                reset_calculator,
    input  logic [9:0]          switches,
    input  calc_pkg::op_code_t  operation,
    calc_display_if.producer    result_port
);

    calc_pkg::magnitude_t  x_mag;        // clamped x magnitude
    calc_pkg::magnitude_t  y_mag;        // clamped y magnitude
    logic signed [7:0]     x_value;      // x as two's complement
    logic signed [7:0]     y_value;      // y as two's complement
    logic signed [7:0]     result_value; // signed result, -81 to 81
    logic [7:0]            result_abs;   // absolute value of result

    ////////////////////////////////////////
    // clamp and sign extend
    ////////////////////////////////////////

    assign x_mag = (switches[3:0] > `CALC_MAG_MAX) ? `CALC_MAG_MAX : switches[3:0];
    assign y_mag = (switches[8:5] > `CALC_MAG_MAX) ? `CALC_MAG_MAX : switches[8:5];

    assign x_value = switches[4] ? -$signed({4'b0000, x_mag})
                                 : $signed({4'b0000, x_mag}); // bit 4 is x sign
    assign y_value = switches[9] ? -$signed({4'b0000, y_mag})
                                 : $signed({4'b0000, y_mag}); // bit 9 is y sign

    ////////////////////////////////////////
    // arithmetic
    ////////////////////////////////////////

    always_comb
    begin
        case (operation)
            `CALC_OP_ADD: result_value = x_value + y_value;   // -18 to 18
            `CALC_OP_SUB: result_value = x_value - y_value;   // -18 to 18
            `CALC_OP_MUL: result_value = x_value * y_value;   // -81 to 81
            default:      result_value = 8'sd0;               // no operation
        endcase
    end

    assign result_abs = result_value[7] ? -result_value : result_value;

    ////////////////////////////////////////
    // output registers
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_calculator)
    begin
        if (reset_calculator)
        begin
            result_port.valid      <= 1'b0;
            result_port.x          <= '0;
            result_port.y          <= '0;
            result_port.op         <= '0;
            result_port.result_mag <= '0;
            result_port.result_neg <= 1'b0;
        end
        else
        begin
            result_port.valid      <= 1'b1;                    // set on first edge
            result_port.x          <= {switches[4], x_mag};
            result_port.y          <= {switches[9], y_mag};
            result_port.op         <= operation;
            result_port.result_mag <= result_abs[6:0];         // never above 81
            result_port.result_neg <= result_value[7] && (result_abs != 8'd0); // no minus zero
        end
    end

endmodule

// ==== verilog/display_frame_builder.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module display_frame_builder (
    calc_display_if.consumer     result_port,
    input  calc_pkg::digit_sel_t digit_sel,
    output calc_pkg::segments_t  glyph
);

    calc_pkg::magnitude_t  tens;          // result tens digit
    calc_pkg::magnitude_t  ones;          // result ones digit
    calc_pkg::magnitude_t  op_digit;      // digit standing for the operation
    calc_pkg::segments_t   x_glyph;
    calc_pkg::segments_t   y_glyph;
    calc_pkg::segments_t   tens_glyph;
    calc_pkg::segments_t   ones_glyph;
    calc_pkg::segments_t   op_glyph;

    // minus sign or nothing
    function automatic calc_pkg::segments_t sign_glyph(input logic negative);
        return negative ? `CALC_GLYPH_MINUS : `CALC_GLYPH_BLANK;
    endfunction

    ////////////////////////////////////////
    // digit split
    ////////////////////////////////////////

    assign tens = calc_pkg::magnitude_t'(result_port.result_mag / 7'd10); // 0 to 8
    assign ones = calc_pkg::magnitude_t'(result_port.result_mag % 7'd10); // 0 to 9

    always_comb
    begin
        case (result_port.op)
            `CALC_OP_ADD: op_digit = `CALC_OP_DIGIT_ADD;
            `CALC_OP_SUB: op_digit = `CALC_OP_DIGIT_SUB;
            `CALC_OP_MUL: op_digit = `CALC_OP_DIGIT_MUL;
            default:      op_digit = 4'd0;           // masked below
        endcase
    end

    ////////////////////////////////////////
    // decoders
    ////////////////////////////////////////

    segment_decoder i_x_decoder    (.digit(result_port.x[3:0]), .sseg(x_glyph));
    segment_decoder i_y_decoder    (.digit(result_port.y[3:0]), .sseg(y_glyph));
    segment_decoder i_ones_decoder (.digit(ones),               .sseg(ones_glyph));
    segment_decoder i_tens_decoder (.digit(tens),               .sseg(tens_glyph));
    segment_decoder i_op_decoder   (.digit(op_digit),           .sseg(op_glyph));

    // position table
    always_comb
    begin
        if (!result_port.valid)
        begin
            glyph = `CALC_GLYPH_BLANK;             // nothing loaded yet
        end
        else
        begin
            case (digit_sel)
                3'd0:    glyph = x_glyph;
                3'd1:    glyph = sign_glyph(result_port.x[4]);    // x sign
                3'd2:    glyph = y_glyph;
                3'd3:    glyph = sign_glyph(result_port.y[4]);    // y sign
                3'd4:    glyph = ones_glyph;
                3'd5:    glyph = tens_glyph;
                3'd6:    glyph = sign_glyph(result_port.result_neg);
                default: glyph = (result_port.op == `CALC_OP_NONE) ? `CALC_GLYPH_BLANK
                                                                   : op_glyph;
            endcase
        end
    end

endmodule

// ==== verilog/display_scanner.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module display_scanner #(
    parameter int refresh_ticks = `CALC_REFRESH_TICKS
) (
    input  logic                  clk,
    input  logic                  reset_calculator,
    input  calc_pkg::segments_t   glyph,
    output calc_pkg::digit_sel_t  digit_sel,
    output calc_pkg::segments_t   sseg,
    output calc_pkg::anode_t      anodes
);

    localparam int tick_width = (refresh_ticks > 1) ? $clog2(refresh_ticks) : 1;
    localparam logic [tick_width-1:0] tick_last = tick_width'(refresh_ticks - 1);

    logic [tick_width-1:0]  tick_count;   // cycles spent on current digit
    calc_pkg::digit_sel_t   digit_count;  // digit being lit
    logic                   tick_wrap;    // last cycle of this digit

    assign tick_wrap = (tick_count == tick_last);

    ////////////////////////////////////////
    // refresh divider and digit counter
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_calculator)
    begin
        if (reset_calculator)
        begin
            tick_count  <= '0;
            digit_count <= '0;            // start on position 0
        end
        else if (tick_wrap)
        begin
            tick_count  <= '0;
            digit_count <= digit_count + 3'd1; // 7 wraps to 0
        end
        else
        begin
            tick_count  <= tick_count + 1'b1;
        end
    end

    // one-cold anode enable
    assign anodes    = ~(8'b0000_0001 << digit_count);
    assign digit_sel = digit_count;       // to the frame builder
    assign sseg      = glyph;             // glyph arrives combinationally

endmodule

// ==== verilog/calculator_top.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module calculator_top #(
    parameter int refresh_ticks = `CALC_REFRESH_TICKS
) (
    input  logic        clk,
    input  logic        reset_calculator,
    input  logic [9:0]  switches,         // y in 9:5, x in 4:0
    input  logic [1:0]  operation,        // add, sub, mul, none
    output logic [6:0]  sseg,             // active low, g down to a
    output logic [7:0]  anodes            // active low digit enables
);

    calc_pkg::digit_sel_t  digit_sel;     // position being scanned
    calc_pkg::segments_t   glyph;         // pattern for that position

    calc_display_if calc_bus ();          // calculator to display

    operand_calculator i_operand_calculator (
        .clk              (clk),
        .reset_calculator (reset_calculator),
        .switches         (switches),
        .operation        (operation),
        .result_port      (calc_bus.producer)
    );

    display_frame_builder i_display_frame_builder (
        .result_port (calc_bus.consumer),
        .digit_sel   (digit_sel),
        .glyph       (glyph)
    );

    display_scanner #(
        .refresh_ticks (refresh_ticks)
    ) i_display_scanner (
        .clk              (clk),
        .reset_calculator (reset_calculator),
        .glyph            (glyph),
        .digit_sel        (digit_sel),
        .sseg             (sseg),
        .anodes           (anodes)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

// 4 ns clock and a reset held for the first 16 cycles
module tb_clock_gen (
    output logic clk,
    output logic reset_calculator
);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;           // 4 ns period
    end

    initial
    begin
        reset_calculator = 1'b1;
        repeat (16) @(posedge clk);
        #1 reset_calculator = 1'b0;      // release just after an edge
    end

endmodule

// ==== verification/tb_calculator_top.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module tb_calculator_top;

    localparam int refresh_ticks  = 4;   // short scan period
    localparam int timeout_cycles = 40 * 8 * refresh_ticks * 2 + 200;

    logic                 clk;
    logic                 reset_calculator;
    logic [9:0]           switches;      // y in 9:5 and x in 4:0
    calc_pkg::op_code_t   operation;
    calc_pkg::segments_t  sseg;
    calc_pkg::anode_t     anodes;
    logic [31:0]          lfsr_state;    // random operand source
    int                   cycle_count;

    tb_clock_gen i_tb_clock_gen (.clk(clk), .reset_calculator(reset_calculator));

    calculator_top #(.refresh_ticks(refresh_ticks)) i_calculator_top (
        .clk              (clk),
        .reset_calculator (reset_calculator),
        .switches         (switches),
        .operation        (operation),
        .sseg             (sseg),
        .anodes           (anodes)
    );

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic calc_pkg::segments_t digit_pattern(input int digit);
        case (digit)
            0:       return 7'b1000000;
            1:       return 7'b1111001;
            2:       return 7'b0100100;
            3:       return 7'b0110000;
            4:       return 7'b0011001;
            5:       return 7'b0010010;
            6:       return 7'b0000010;
            7:       return 7'b1111000;
            8:       return 7'b0000000;
            9:       return 7'b0010000;
            default: return `CALC_GLYPH_BLANK;
        endcase
    endfunction

    function automatic int clamped(input logic [3:0] mag);
        return (mag > 4'd9) ? 9 : int'(mag);          // 10 to 15 shown as 9
    endfunction

    function automatic calc_pkg::segments_t sign_pattern(input logic negative);
        return negative ? `CALC_GLYPH_MINUS : `CALC_GLYPH_BLANK;
    endfunction

    function automatic calc_pkg::segments_t expected_glyph(input logic [9:0] sw,
                                                           input calc_pkg::op_code_t op,
                                                           input int pos);
        int x_val;
        int y_val;
        int result;
        int mag;
        x_val = sw[4] ? -clamped(sw[3:0]) : clamped(sw[3:0]);
        y_val = sw[9] ? -clamped(sw[8:5]) : clamped(sw[8:5]);
        case (op)
            `CALC_OP_ADD: result = x_val + y_val;
            `CALC_OP_SUB: result = x_val - y_val;
            `CALC_OP_MUL: result = x_val * y_val;
            default:      result = 0;               // code 11
        endcase
        mag = (result < 0) ? -result : result;
        case (pos)
            0:       return digit_pattern(clamped(sw[3:0]));
            1:       return sign_pattern(sw[4]);
            2:       return digit_pattern(clamped(sw[8:5]));
            3:       return sign_pattern(sw[9]);
            4:       return digit_pattern(mag % 10);
            5:       return digit_pattern(mag / 10);
            6:       return sign_pattern(result < 0);   // zero never negative
            default: return (op == 2'b11) ? `CALC_GLYPH_BLANK
                                          : digit_pattern((op == 2'b00) ? 2 : (op == 2'b01) ? 4 : 7);
        endcase
    endfunction

    function automatic calc_pkg::anode_t one_cold(input int pos);
        calc_pkg::anode_t pattern;
        for (int b = 0; b < 8; b++)
            pattern[b] = (b != pos);                  // only the lit digit low
        return pattern;
    endfunction

    ////////////////////////////////////////
    // compare tasks, LFSR and timeout
    ////////////////////////////////////////

    task automatic compare_segments(input string name, input calc_pkg::segments_t expected,
                                    input calc_pkg::segments_t actual);
        if (actual !== expected)
        begin
            $display("FAIL %s expected 0x%h actual 0x%h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "segment mismatch");
        end
    endtask

    task automatic compare_anodes(input string name, input calc_pkg::anode_t expected,
                                  input calc_pkg::anode_t actual);
        if (actual !== expected)
        begin
            $display("FAIL %s expected 0x%h actual 0x%h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "anode mismatch");
        end
    endtask

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        repeat (count)
        begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            value = {value[30:0], lfsr_state[0]};      // one step per bit
        end
        return value;
    endfunction

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles)
        begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic run_case(input logic [9:0] sw, input calc_pkg::op_code_t op);
        int start;
        int pos;
        @(posedge clk);
        #1;
        switches  = sw;                  // drive just after the edge
        operation = op;
        repeat (2) @(posedge clk);
        @(negedge clk);
        start = -1;
        for (int p = 0; p < 8; p++)
        begin
            if (anodes === one_cold(p))
                start = p;
        end
        if (start < 0)
        begin
            $display("error: no single digit is lit, anodes are 0x%h", anodes);
            $display("SIMULATION FAILED");
            $fatal(1, "bad anodes");
        end
        for (int i = 0; i < 8; i++)
        begin
            pos = (start + i) % 8;
            while (anodes !== one_cold(pos))
                @(negedge clk);           // sample mid cycle
            compare_segments($sformatf("sseg[pos %0d]", pos), expected_glyph(sw, op, pos), sseg);
        end
    endtask

    task automatic check_reset_and_scan();
        @(posedge clk);
        @(negedge clk);
        compare_anodes("anodes", 8'b1111_1110, anodes);         // position 0 in reset
        compare_segments("sseg", `CALC_GLYPH_BLANK, sseg);      // valid still low
        @(negedge reset_calculator);
        @(negedge clk);
        compare_anodes("anodes[pos 0]", one_cold(0), anodes);
        for (int n = 1; n <= 9 * refresh_ticks; n++)
        begin
            @(negedge clk);
            compare_anodes($sformatf("anodes[pos %0d]", (n / refresh_ticks) % 8),
                           one_cold((n / refresh_ticks) % 8), anodes);   // wraps 7 to 0
        end
    endtask

    task automatic check_arithmetic();
        run_case({1'b0, 4'd4, 1'b0, 4'd3}, 2'b00);    // 3 + 4
        run_case({1'b0, 4'd2, 1'b1, 4'd7}, 2'b00);    // -7 + 2 crosses zero
        run_case({1'b1, 4'd5, 1'b0, 4'd5}, 2'b00);    // zero without minus
        run_case({1'b1, 4'd9, 1'b0, 4'd9}, 2'b01);    // 9 - -9
        run_case({1'b0, 4'd6, 1'b1, 4'd3}, 2'b01);    // -3 - 6
        run_case({1'b0, 4'd9, 1'b0, 4'd9}, 2'b10);    // 81
        run_case({1'b0, 4'd9, 1'b1, 4'd9}, 2'b10);    // -81
        run_case({1'b1, 4'd5, 1'b0, 4'd0}, 2'b10);    // 0 times -5
    endtask

    task automatic check_clamp_and_ops();
        run_case({1'b1, 4'd12, 1'b0, 4'd15}, 2'b10);  // both clamp to 9
        run_case({1'b0, 4'd13, 1'b1, 4'd10}, 2'b01);
        for (int op = 0; op < 4; op++)
            run_case({1'b1, 4'd2, 1'b0, 4'd6}, op[1:0]); // digits 2, 4 and 7, then blank
    endtask

    initial
    begin
        logic [31:0] sw_bits;
        logic [31:0] op_bits;
        switches    = '0;
        operation   = '0;
        lfsr_state  = 32'hb110;
        cycle_count = 0;
        check_reset_and_scan();
        check_arithmetic();
        check_clamp_and_ops();
        repeat (30)
        begin
            sw_bits = take_bits(10);
            op_bits = take_bits(2);
            run_case(sw_bits[9:0], op_bits[1:0]);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/calc_pkg.sv
verilog/calc_display_if.sv
verilog/segment_decoder.sv
verilog/operand_calculator.sv
verilog/display_frame_builder.sv
verilog/display_scanner.sv
verilog/calculator_top.sv
verification/tb_clock_gen.sv
verification/tb_calculator_top.sv

// ==== Bender.yml ====
package:
  name: calculator

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/calc_pkg.sv
      - verilog/calc_display_if.sv
      - verilog/segment_decoder.sv
      - verilog/operand_calculator.sv
      - verilog/display_frame_builder.sv
      - verilog/display_scanner.sv
      - verilog/calculator_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_calculator_top.sv
